/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_tlb_mmu
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) tlb_defs.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(OBJ_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
+incdir+.
tlb_pkg.sv
tlb_entry_array.sv
tlb_lookup.sv
tlb_cp0_ctrl.sv
tlb_mmu_top.sv
tlb_mmu_sva.sv
tb_tlb_mmu.sv

/* tb_tlb_mmu.sv */
`timescale 1ns/100ps
`include "tlb_defs.svh"

module tb_tlb_mmu
    import tlb_pkg::*;
();

    localparam int RESET_CYCLES = 5;
    localparam int IDLE_CHECKS  = 16;
    localparam int N_OPS        = 1500;
    localparam int TIMEOUT      = RESET_CYCLES + IDLE_CHECKS + N_OPS + 100;

    localparam int OP_IDLE  = 0;
    localparam int OP_MTC0  = 1;
    localparam int OP_TLBWI = 2;
    localparam int OP_TLBR  = 3;
    localparam int OP_TLBP  = 4;

    logic        aclk;
    logic        arst_n;
    vpn2_t       if_vpn2;
    logic        if_odd_page;
    logic        if_found;
    pfn_t        if_pfn;
    cattr_t      if_c;
    logic        if_d;
    logic        if_v;
    vpn2_t       dm_vpn2;
    logic        dm_odd_page;
    logic        dm_found;
    pfn_t        dm_pfn;
    cattr_t      dm_c;
    logic        dm_d;
    logic        dm_v;
    logic        mtc0_we;
    logic [4:0]  c0_addr;
    logic [31:0] c0_wdata;
    logic        tlbwi;
    logic        tlbr;
    logic        tlbp;
    logic [31:0] c0_rdata;

    // reference model state
    tlb_entry_t  m_entries [`TLB_ENTRIES];
    logic        m_p;
    tlb_idx_t    m_idx;
    vpn2_t       m_vpn2;
    asid_t       m_asid;
    logic [25:0] m_lo0;
    logic [25:0] m_lo1;

    integer      seed;
    int          err_count;
    int          hit_count;
    int          cycle_count = 0;

    tlb_mmu_top DUT (.*);

    initial aclk = 1'b0;
    always #2 aclk = ~aclk;

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("the tests did not finish within %0d cycles", TIMEOUT);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR: %s expected %h got %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(input logic [31:0] exp, input logic [31:0] act);
        compare_field("c0_rdata", exp, act);
    endtask

    task automatic check_lookup(
        input string  port,
        input logic   exp_found, act_found,
        input pfn_t   exp_pfn, act_pfn,
        input cattr_t exp_c, act_c,
        input logic   exp_d, act_d,
        input logic   exp_v, act_v
    );
        compare_field({port, "_found"}, 32'(exp_found), 32'(act_found));
        compare_field({port, "_pfn"}, 32'(exp_pfn), 32'(act_pfn));
        compare_field({port, "_c"}, 32'(exp_c), 32'(act_c));
        compare_field({port, "_d"}, 32'(exp_d), 32'(act_d));
        compare_field({port, "_v"}, 32'(exp_v), 32'(act_v));
    endtask

    // small pools so that hits, asid misses and duplicates all show up
    function automatic vpn2_t pick_vpn2(input logic [31:0] r);
        case (r[1:0])
            2'd0:    return 19'h00011;
            2'd1:    return 19'h00012;
            2'd2:    return 19'h7ff40;
            default: return 19'h12345;
        endcase
    endfunction

    function automatic asid_t pick_asid(input logic [31:0] r);
        case (r[1:0])
            2'd0:    return 8'h00;
            2'd2:    return 8'h5a;
            default: return 8'h01;
        endcase
    endfunction

    function automatic logic [4:0] pick_addr(input logic [31:0] r);
        case (r[2:0])
            3'd0, 3'd1: return `CP0_INDEX;
            3'd2:       return `CP0_ENTRYLO0;
            3'd3:       return `CP0_ENTRYLO1;
            3'd4, 3'd5: return `CP0_ENTRYHI;
            default:    return r[7:3];
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [4:0] addr);
        case (addr)
            `CP0_INDEX:    return {m_p, 27'b0, m_idx};
            `CP0_ENTRYHI:  return {m_vpn2, 5'b0, m_asid};
            `CP0_ENTRYLO0: return {6'b0, m_lo0};
            `CP0_ENTRYLO1: return {6'b0, m_lo1};
            default:       return 32'h0;
        endcase
    endfunction

    // lowest matching index wins and a miss returns all zero
    task automatic model_search(input vpn2_t key, input logic odd, input asid_t asid,
                                output logic f, output tlb_idx_t ix, output pfn_t p,
                                output cattr_t c, output logic d, output logic v);
        tlb_entry_t e;
        f  = 1'b0;
        ix = '0;
        e  = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (!f && m_entries[i].vpn2 == key &&
                (m_entries[i].g || m_entries[i].asid == asid)) begin
                f  = 1'b1;
                ix = tlb_idx_t'(i);
                e  = m_entries[i];
            end
        end
        p = odd ? e.pfn1 : e.pfn0;
        c = odd ? e.c1 : e.c0;
        d = odd ? e.d1 : e.d0;
        v = odd ? e.v1 : e.v0;
    endtask

    task automatic run_op(input int kind);
        logic [31:0] r;
        logic [4:0]  addr;
        logic [31:0] wdata;
        vpn2_t       if_key;
        vpn2_t       dm_key;
        logic        if_odd;
        logic        dm_odd;
        logic        f;
        tlb_idx_t    ix;
        pfn_t        p;
        cattr_t      c;
        logic        d;
        logic        v;
        tlb_entry_t  e;
        r     = $random(seed);
        addr  = pick_addr(r);
        wdata = $random(seed);
        if (kind == OP_MTC0 && addr == `CP0_ENTRYHI) begin
            wdata[31:13] = pick_vpn2(r >> 8);
            wdata[7:0]   = pick_asid(r >> 12);
        end
        r      = $random(seed);
        if_key = pick_vpn2(r);
        dm_key = pick_vpn2(r >> 4);
        if_odd = r[8];
        dm_odd = r[9];
        @(posedge aclk);
        mtc0_we     <= (kind == OP_MTC0);
        tlbwi       <= (kind == OP_TLBWI);
        tlbr        <= (kind == OP_TLBR);
        tlbp        <= (kind == OP_TLBP);
        c0_addr     <= addr;
        c0_wdata    <= wdata;
        if_vpn2     <= if_key;
        if_odd_page <= if_odd;
        dm_vpn2     <= dm_key;
        dm_odd_page <= dm_odd;
        @(negedge aclk);
        check_word(model_read(addr), c0_rdata);
        model_search(if_key, if_odd, m_asid, f, ix, p, c, d, v);
        if (f) hit_count++;
        check_lookup("if", f, if_found, p, if_pfn, c, if_c, d, if_d, v, if_v);
        model_search(dm_key, dm_odd, m_asid, f, ix, p, c, d, v);
        check_lookup("dm", f, dm_found, p, dm_pfn, c, dm_c, d, dm_d, v, dm_v);
        // model follows the op that takes effect at the next edge
        case (kind)
            OP_MTC0: begin
                case (addr)
                    `CP0_INDEX: begin
                        m_p   = wdata[31];
                        m_idx = wdata[`TLB_IDX_W-1:0];
                    end
                    `CP0_ENTRYHI: begin
                        m_vpn2 = wdata[31:13];
                        m_asid = wdata[7:0];
                    end
                    `CP0_ENTRYLO0: m_lo0 = wdata[25:0];
                    `CP0_ENTRYLO1: m_lo1 = wdata[25:0];
                    default: ;
                endcase
            end
            OP_TLBWI: begin
                e.vpn2 = m_vpn2;
                e.asid = m_asid;
                e.g    = m_lo0[0] & m_lo1[0];
                e.pfn0 = m_lo0[25:6];
                e.c0   = m_lo0[5:3];
                e.d0   = m_lo0[2];
                e.v0   = m_lo0[1];
                e.pfn1 = m_lo1[25:6];
                e.c1   = m_lo1[5:3];
                e.d1   = m_lo1[2];
                e.v1   = m_lo1[1];
                m_entries[m_idx] = e;
            end
            OP_TLBR: begin
                e      = m_entries[m_idx];
                m_vpn2 = e.vpn2;
                m_asid = e.asid;
                m_lo0  = {e.pfn0, e.c0, e.d0, e.v0, e.g};
                m_lo1  = {e.pfn1, e.c1, e.d1, e.v1, e.g};
            end
            OP_TLBP: begin
                model_search(m_vpn2, 1'b0, m_asid, f, ix, p, c, d, v);
                m_p = !f;
                if (f) m_idx = ix;
            end
            default: ;
        endcase
    endtask

    initial begin
        logic [31:0] r;
        seed        = 32'h2350;
        err_count   = 0;
        hit_count   = 0;
        arst_n      <= 1'b0;
        mtc0_we     <= 1'b0;
        c0_addr     <= '0;
        c0_wdata    <= '0;
        tlbwi       <= 1'b0;
        tlbr        <= 1'b0;
        tlbp        <= 1'b0;
        if_vpn2     <= '0;
        if_odd_page <= 1'b0;
        dm_vpn2     <= '0;
        dm_odd_page <= 1'b0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            m_entries[i] = '0;
        end
        m_p    = 1'b0;
        m_idx  = '0;
        m_vpn2 = '0;
        m_asid = '0;
        m_lo0  = '0;
        m_lo1  = '0;
        repeat (RESET_CYCLES) @(posedge aclk);
        arst_n <= 1'b1;
        // empty TLB and cleared registers first
        repeat (IDLE_CHECKS) run_op(OP_IDLE);
        for (int n = 0; n < N_OPS; n++) begin
            r = $random(seed);
            case (r % 32'd10)
                0, 1, 2, 3: run_op(OP_MTC0);
                4, 5:       run_op(OP_TLBWI);
                6:          run_op(OP_TLBR);
                7, 8:       run_op(OP_TLBP);
                default:    run_op(OP_IDLE);
            endcase
        end
        @(posedge aclk);
        if (hit_count == 0) begin
            $display("no lookup hit occurred during the random run");
            err_count++;
        end
        if (err_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

/* tlb_cp0_ctrl.sv */
`timescale 1ns/100ps
`include "tlb_defs.svh"

module tlb_cp0_ctrl
    import tlb_pkg::*;
(
    input  logic        aclk,
    input  logic        arst_n,

    // MTC0/MFC0 access
    input  logic        mtc0_we,
    input  logic [4:0]  c0_addr,
    input  logic [31:0] c0_wdata,
    output logic [31:0] c0_rdata,

    // TLB instructions as single-cycle pulses
    input  logic        tlbwi,
    input  logic        tlbr,
    input  logic        tlbp,

    // probe lookup
    output asid_t       cur_asid,
    output vpn2_t       probe_vpn2,
    input  logic        probe_found,
    input  tlb_idx_t    probe_idx,

    // entry array ports
    output logic        wr_en,
    output tlb_idx_t    wr_idx,
    output tlb_entry_t  wr_entry,
    output tlb_idx_t    rd_idx,
    input  tlb_entry_t  rd_entry
);

    // Index
    logic        index_p_q;
    tlb_idx_t    index_q;
    // EntryHi
    vpn2_t       ehi_vpn2_q;
    asid_t       ehi_asid_q;
    // EntryLo0/1 keep only bits 25..0 and the rest read as zero
    logic [25:0] lo0_q;
    logic [25:0] lo1_q;

    logic        wr_index;
    logic        wr_entryhi;
    logic        wr_entrylo0;
    logic        wr_entrylo1;

    assign wr_index    = mtc0_we && (c0_addr == `CP0_INDEX);
    assign wr_entryhi  = mtc0_we && (c0_addr == `CP0_ENTRYHI);
    assign wr_entrylo0 = mtc0_we && (c0_addr == `CP0_ENTRYLO0);
    assign wr_entrylo1 = mtc0_we && (c0_addr == `CP0_ENTRYLO1);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            index_p_q <= 1'b0;
            index_q   <= '0;
        end else if (wr_index) begin
            index_p_q <= c0_wdata[31];
            index_q   <= c0_wdata[`TLB_IDX_W-1:0];
        end else if (tlbp) begin
            // a failed probe leaves the index field alone
            index_p_q <= !probe_found;
            if (probe_found) begin
                index_q <= probe_idx;
            end
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            ehi_vpn2_q <= '0;
            ehi_asid_q <= '0;
        end else if (wr_entryhi) begin
            ehi_vpn2_q <= c0_wdata[31:13];
            ehi_asid_q <= c0_wdata[7:0];
        end else if (tlbr) begin
            ehi_vpn2_q <= rd_entry.vpn2;
            ehi_asid_q <= rd_entry.asid;
        end
    end

    // TLBR copies the single global flag into both g bits
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            lo0_q <= '0;
            lo1_q <= '0;
        end else if (wr_entrylo0) begin
            lo0_q <= c0_wdata[25:0];
        end else if (wr_entrylo1) begin
            lo1_q <= c0_wdata[25:0];
        end else if (tlbr) begin
            lo0_q <= {rd_entry.pfn0, rd_entry.c0, rd_entry.d0, rd_entry.v0, rd_entry.g};
            lo1_q <= {rd_entry.pfn1, rd_entry.c1, rd_entry.d1, rd_entry.v1, rd_entry.g};
        end
    end

    // MFC0 read mux
    always_comb begin
        case (c0_addr)
            `CP0_INDEX:    c0_rdata = {index_p_q, {(31 - `TLB_IDX_W){1'b0}}, index_q};
            `CP0_ENTRYHI:  c0_rdata = {ehi_vpn2_q, 5'b0, ehi_asid_q};
            `CP0_ENTRYLO0: c0_rdata = {6'b0, lo0_q};
            `CP0_ENTRYLO1: c0_rdata = {6'b0, lo1_q};
            default:       c0_rdata = 32'h0;
        endcase
    end

    // entry built from EntryHi and both EntryLo registers
    always_comb begin
        wr_entry.vpn2 = ehi_vpn2_q;
        wr_entry.asid = ehi_asid_q;
        wr_entry.g    = lo0_q[0] & lo1_q[0];
        wr_entry.pfn0 = lo0_q[25:6];
        wr_entry.c0   = lo0_q[5:3];
        wr_entry.d0   = lo0_q[2];
        wr_entry.v0   = lo0_q[1];
        wr_entry.pfn1 = lo1_q[25:6];
        wr_entry.c1   = lo1_q[5:3];
        wr_entry.d1   = lo1_q[2];
        wr_entry.v1   = lo1_q[1];
    end

    assign wr_en  = tlbwi;
    assign wr_idx = index_q;
    assign rd_idx = index_q;

    // every search runs under the current asid
    assign cur_asid   = ehi_asid_q;
    assign probe_vpn2 = ehi_vpn2_q;

endmodule

/* tlb_defs.svh */
`ifndef TLB_DEFS_SVH
`define TLB_DEFS_SVH

// TLB geometry
`define TLB_ENTRIES  16
`define TLB_IDX_W    4

// field widths of a stored entry
`define VPN2_W       19
`define PFN_W        20
`define ASID_W       8

// CP0 register numbers seen by MTC0/MFC0
`define CP0_INDEX    5'd0
`define CP0_ENTRYLO0 5'd2
`define CP0_ENTRYLO1 5'd3
`define CP0_ENTRYHI  5'd10

`endif

/* tlb_entry_array.sv */
`timescale 1ns/100ps
`include "tlb_defs.svh"

module tlb_entry_array
    import tlb_pkg::*;
(
    input  logic       aclk,
    input  logic       arst_n,

    // write port takes one whole entry per pulse
    input  logic       wr_en,
    input  tlb_idx_t   wr_idx,
    input  tlb_entry_t wr_entry,

    // indexed read port for TLBR
    input  tlb_idx_t   rd_idx,
    output tlb_entry_t rd_entry,

    // all entries for the associative search
    output tlb_entry_t entries [`TLB_ENTRIES]
);

    tlb_entry_t entry_q [`TLB_ENTRIES];

    // cleared entries carry g = 0 and v = 0 on both pages
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                entry_q[i] <= '0;
            end
        end else if (wr_en) begin
            entry_q[wr_idx] <= wr_entry;
        end
    end

    assign rd_entry = entry_q[rd_idx];

    // new contents are visible to the lookups from the write edge on
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            entries[i] = entry_q[i];
        end
    end

endmodule

/* tlb_lookup.sv */
`timescale 1ns/100ps
`include "tlb_defs.svh"

module tlb_lookup
    import tlb_pkg::*;
(
    input  tlb_entry_t entries [`TLB_ENTRIES],

    // search key
    input  vpn2_t      vpn2,
    input  logic       odd_page,
    input  asid_t      asid,

    // result
    output logic       found,
    output tlb_idx_t   idx,
    output pfn_t       pfn,
    output cattr_t     c,
    output logic       d,
    output logic       v
);

    logic [`TLB_ENTRIES-1:0] hit;
    tlb_entry_t              sel;

    // global entries ignore the asid
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            hit[i] = (entries[i].vpn2 == vpn2) &&
                     (entries[i].g || (entries[i].asid == asid));
        end
    end

    // scan downwards so the lowest matching index is the one kept
    always_comb begin
        found = 1'b0;
        idx   = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                found = 1'b1;
                idx   = tlb_idx_t'(i);
            end
        end
    end

    // a miss forces every page field to zero
    assign sel = found ? entries[idx] : '0;

    always_comb begin
        if (odd_page) begin
            pfn = sel.pfn1;
            c   = sel.c1;
            d   = sel.d1;
            v   = sel.v1;
        end else begin
            pfn = sel.pfn0;
            c   = sel.c0;
            d   = sel.d0;
            v   = sel.v0;
        end
    end

endmodule

/* tlb_mmu_sva.sv */
`timescale 1ns/100ps
`include "tlb_defs.svh"

module tlb_mmu_sva
    import tlb_pkg::*;
(
    input logic        aclk,
    input logic        arst_n,
    input logic        mtc0_we,
    input logic        tlbwi,
    input logic        tlbr,
    input logic        tlbp,
    input logic [4:0]  c0_addr,
    input logic [31:0] c0_rdata,
    input logic        if_found,
    input logic        if_v,
    input pfn_t        if_pfn,
    input logic        dm_found,
    input logic        dm_v,
    input pfn_t        dm_pfn
);

    // one CP0 operation per cycle
    a_one_op: assert property (@(posedge aclk) disable iff (!arst_n)
        $onehot0({mtc0_we, tlbwi, tlbr, tlbp}))
        else $error("more than one CP0 or TLB operation in a cycle");

    a_if_miss: assert property (@(posedge aclk) disable iff (!arst_n)
        !if_found |-> (!if_v && if_pfn == '0))
        else $error("fetch lookup misses but returns page fields");

    a_dm_miss: assert property (@(posedge aclk) disable iff (!arst_n)
        !dm_found |-> (!dm_v && dm_pfn == '0))
        else $error("data lookup misses but returns page fields");

    a_index_zero: assert property (@(posedge aclk) disable iff (!arst_n)
        (c0_addr == `CP0_INDEX) |-> (c0_rdata[30:`TLB_IDX_W] == '0))
        else $error("Index reads nonzero in bits 30..4");

endmodule

bind tlb_mmu_top tlb_mmu_sva sva (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .mtc0_we  (mtc0_we),
    .tlbwi    (tlbwi),
    .tlbr     (tlbr),
    .tlbp     (tlbp),
    .c0_addr  (c0_addr),
    .c0_rdata (c0_rdata),
    .if_found (if_found),
    .if_v     (if_v),
    .if_pfn   (if_pfn),
    .dm_found (dm_found),
    .dm_v     (dm_v),
    .dm_pfn   (dm_pfn)
);

/* tlb_mmu_top.sv */
`timescale 1ns/100ps
`include "tlb_defs.svh"

module tlb_mmu_top
    import tlb_pkg::*;
(
    input  logic        aclk,
    input  logic        arst_n,

    // fetch search
    input  vpn2_t       if_vpn2,
    input  logic        if_odd_page,
    output logic        if_found,
    output pfn_t        if_pfn,
    output cattr_t      if_c,
    output logic        if_d,
    output logic        if_v,

    // data search
    input  vpn2_t       dm_vpn2,
    input  logic        dm_odd_page,
    output logic        dm_found,
    output pfn_t        dm_pfn,
    output cattr_t      dm_c,
    output logic        dm_d,
    output logic        dm_v,

    // CP0 access and TLB instructions
    input  logic        mtc0_we,
    input  logic [4:0]  c0_addr,
    input  logic [31:0] c0_wdata,
    input  logic        tlbwi,
    input  logic        tlbr,
    input  logic        tlbp,
    output logic [31:0] c0_rdata
);

    tlb_entry_t entries [`TLB_ENTRIES];

    asid_t      cur_asid;
    vpn2_t      probe_vpn2;
    logic       probe_found;
    tlb_idx_t   probe_idx;

    logic       wr_en;
    tlb_idx_t   wr_idx;
    tlb_entry_t wr_entry;
    tlb_idx_t   rd_idx;
    tlb_entry_t rd_entry;

    tlb_cp0_ctrl cp0_ctrl (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .mtc0_we     (mtc0_we),
        .c0_addr     (c0_addr),
        .c0_wdata    (c0_wdata),
        .c0_rdata    (c0_rdata),
        .tlbwi       (tlbwi),
        .tlbr        (tlbr),
        .tlbp        (tlbp),
        .cur_asid    (cur_asid),
        .probe_vpn2  (probe_vpn2),
        .probe_found (probe_found),
        .probe_idx   (probe_idx),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_entry    (wr_entry),
        .rd_idx      (rd_idx),
        .rd_entry    (rd_entry)
    );

    tlb_entry_array entry_array (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_entry (wr_entry),
        .rd_idx   (rd_idx),
        .rd_entry (rd_entry),
        .entries  (entries)
    );

    tlb_lookup fetch_lookup (
        .entries  (entries),
        .vpn2     (if_vpn2),
        .odd_page (if_odd_page),
        .asid     (cur_asid),
        .found    (if_found),
        .idx      (),
        .pfn      (if_pfn),
        .c        (if_c),
        .d        (if_d),
        .v        (if_v)
    );

    tlb_lookup data_lookup (
        .entries  (entries),
        .vpn2     (dm_vpn2),
        .odd_page (dm_odd_page),
        .asid     (cur_asid),
        .found    (dm_found),
        .idx      (),
        .pfn      (dm_pfn),
        .c        (dm_c),
        .d        (dm_d),
        .v        (dm_v)
    );

    // TLBP only needs the hit and its index
    tlb_lookup probe_lookup (
        .entries  (entries),
        .vpn2     (probe_vpn2),
        .odd_page (1'b0),
        .asid     (cur_asid),
        .found    (probe_found),
        .idx      (probe_idx),
        .pfn      (),
        .c        (),
        .d        (),
        .v        ()
    );

endmodule

/* tlb_pkg.sv */
`include "tlb_defs.svh"

package tlb_pkg;

    // one virtual page pair maps an even and an odd page
    typedef logic [`VPN2_W-1:0]    vpn2_t;

    typedef logic [`PFN_W-1:0]     pfn_t;

    typedef logic [`ASID_W-1:0]    asid_t;

    typedef logic [`TLB_IDX_W-1:0] tlb_idx_t;

    // cache attribute is stored and returned only
    typedef logic [2:0]            cattr_t;

    // 78 bits with the tag part first then the even and odd pages
    typedef struct packed {
        vpn2_t  vpn2;
        asid_t  asid;
        logic   g;
        pfn_t   pfn0;
        cattr_t c0;
        logic   d0;
        logic   v0;
        pfn_t   pfn1;
        cattr_t c1;
        logic   d1;
        logic   v1;
    } tlb_entry_t;

endpackage
